//--- dma_regs.sv
`default_nettype none

module dma_regs
  import slv_bus_pkg::*, ethpipe_reg_pkg::*;
(
  input  wire                                  clk_125,
  input  wire                                  sys_rst,
  input  wire reg_wr_t                         reg_wr_i,
  input  wire                                  rx_intr_i,
  output wire [DMA_RD_N-1:0][SLV_DAT_W-1:0]    dma_rd_o,
  output logic [1:0]                           dma_load_o,
  output logic [DMA_LEN_W-1:0]                 dma_length_o,
  output logic [1:0][DMA_ADDR_W-1:0]           dma_addr_start_o,
  output logic                                 sys_intr_o
);

  logic [7:0] status;
  logic       wr;
  logic [1:0] load_nxt;

  // start address byte lanes, hi picks the upper word
  function automatic logic [DMA_ADDR_W-1:0] addr_upd(input logic [DMA_ADDR_W-1:0] a,
                                                     input logic hi, input reg_wr_t w);
    logic [DMA_ADDR_W-1:0] r;
    r = a;
    if (!hi) begin
      if (w.sel[1]) r[5:0] = w.dat[15:10];
      if (w.sel[0]) r[13:6] = w.dat[7:0];
    end else begin
      if (w.sel[1]) r[21:14] = w.dat[15:8];
      if (w.sel[0]) r[29:22] = w.dat[7:0];
    end
    return r;
  endfunction

  assign wr = reg_wr_i.op == OP_WRITE;

  // length feeds both channels
  always_comb begin
    load_nxt = 2'b00;
    if (wr) begin
      case (reg_wr_i.id)
        REG_DMA_LEN_LO, REG_DMA_LEN_HI:     load_nxt = 2'b11;
        REG_DMA1_ADDR_LO, REG_DMA1_ADDR_HI: load_nxt = 2'b01;
        REG_DMA2_ADDR_LO, REG_DMA2_ADDR_HI: load_nxt = 2'b10;
        default:                            load_nxt = 2'b00;
      endcase
    end
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      status              <= '0;
      dma_length_o        <= DMA_LEN_RST;
      dma_addr_start_o[0] <= DMA1_ADDR_RST;
      dma_addr_start_o[1] <= DMA2_ADDR_RST;
      dma_load_o          <= 2'b00;
    end else begin
      dma_load_o <= load_nxt;
      if (rx_intr_i) status[INTR_BIT] <= 1'b1;
      // host write wins over a new interrupt
      if (wr) begin
        case (reg_wr_i.id)
          REG_DMA_STATUS: begin
            if (reg_wr_i.sel[1]) status <= reg_wr_i.dat[15:8];
          end
          REG_DMA_LEN_LO: begin
            if (reg_wr_i.sel[1]) dma_length_o[5:0] <= reg_wr_i.dat[15:10];
            if (reg_wr_i.sel[0]) dma_length_o[13:6] <= reg_wr_i.dat[7:0];
          end
          REG_DMA_LEN_HI: begin
            if (reg_wr_i.sel[1]) dma_length_o[19:14] <= reg_wr_i.dat[13:8];
          end
          REG_DMA1_ADDR_LO: dma_addr_start_o[0] <= addr_upd(dma_addr_start_o[0], 1'b0, reg_wr_i);
          REG_DMA1_ADDR_HI: dma_addr_start_o[0] <= addr_upd(dma_addr_start_o[0], 1'b1, reg_wr_i);
          REG_DMA2_ADDR_LO: dma_addr_start_o[1] <= addr_upd(dma_addr_start_o[1], 1'b0, reg_wr_i);
          REG_DMA2_ADDR_HI: dma_addr_start_o[1] <= addr_upd(dma_addr_start_o[1], 1'b1, reg_wr_i);
          default: ;
        endcase
      end
    end
  end

  assign sys_intr_o = status[INTR_BIT];

  // --------------------
  // read words
  // --------------------
  assign dma_rd_o[DRD_STATUS] = {status, 8'h00};
  assign dma_rd_o[DRD_LEN_LO] = {dma_length_o[5:0], 2'b00, dma_length_o[13:6]};
  assign dma_rd_o[DRD_LEN_HI] = {2'b00, dma_length_o[19:14], 8'h00};

  for (genvar ch = 0; ch < 2; ch++) begin : g_addr
    assign dma_rd_o[DRD_A1_LO + 2*ch] = {dma_addr_start_o[ch][5:0], 2'b00,
                                         dma_addr_start_o[ch][13:6]};
    assign dma_rd_o[DRD_A1_HI + 2*ch] = {dma_addr_start_o[ch][21:14],
                                         dma_addr_start_o[ch][29:22]};
  end

  // back to back pulses need back to back writes
  assert property (@(posedge clk_125) disable iff (sys_rst)
    (|dma_load_o) ##1 (|dma_load_o) |->
      $past(reg_wr_i.op == OP_WRITE, 1) && $past(reg_wr_i.op == OP_WRITE, 2));

endmodule

`default_nettype wire

//--- ethpipe_reg_pkg.sv
`default_nettype none

package ethpipe_reg_pkg;
  import slv_bus_pkg::*;

  // --------------------
  // register map
  // --------------------

  // value is the word offset inside BAR0 page 0
  typedef enum logic [7:0] {
    REG_GCNT0        = 8'h02,
    REG_GCNT1        = 8'h03,
    REG_GCNT2        = 8'h04,
    REG_GCNT3        = 8'h05,
    REG_DMA_STATUS   = 8'h08,
    REG_DMA_LEN_LO   = 8'h0a,
    REG_DMA_LEN_HI   = 8'h0b,
    REG_DMA1_ADDR_LO = 8'h10,
    REG_DMA1_ADDR_HI = 8'h11,
    REG_DMA2_ADDR_LO = 8'h14,
    REG_DMA2_ADDR_HI = 8'h15,
    REG_TX_WR_PTR    = 8'h18,
    REG_TX_RD_PTR    = 8'h1a,
    REG_LTIME_W0     = 8'h80,
    REG_LTIME_W1     = 8'h81,
    REG_LTIME_W2     = 8'h82,
    REG_NONE         = 8'hff
  } reg_id_e;

  typedef enum logic [1:0] {
    OP_IDLE,
    OP_READ,
    OP_WRITE
  } bus_op_e;

  // index space of slots and local times
  localparam int IDX_W      = 3;
  localparam int SLOT_IDX_N = 2;
  localparam int TIME_IDX_N = 8;
  localparam int LT_WORDS   = 3;
  localparam int GCNT_WORDS = 4;
  // write pointers first, then read pointers
  localparam int PTR_RD_N   = 2 * SLOT_IDX_N;

  // dma read word order
  localparam int DMA_RD_N   = 7;
  localparam int DRD_STATUS = 0;
  localparam int DRD_LEN_LO = 1;
  localparam int DRD_LEN_HI = 2;
  localparam int DRD_A1_LO  = 3;
  localparam int DRD_A1_HI  = 4;

  localparam int DMA_LEN_W    = 20;
  localparam int DMA_ADDR_W   = 30;
  localparam int TX_PTR_W     = 14;
  localparam int LOCAL_TIME_W = 48;
  localparam int GCNT_W       = 64;
  localparam int INTR_BIT     = 3;
  localparam int CAPTURE_LAG  = 3;

  // lengths and addresses count 32-bit words
  localparam logic [DMA_LEN_W-1:0]  DMA_LEN_RST   = DMA_LEN_W'(32'h0001_0000 >> 2);
  localparam logic [DMA_ADDR_W-1:0] DMA1_ADDR_RST = DMA_ADDR_W'(32'h1000_0000 >> 2);
  localparam logic [DMA_ADDR_W-1:0] DMA2_ADDR_RST = DMA_ADDR_W'(32'h1010_0000 >> 2);

  // register write strobe, valid when op is OP_WRITE
  typedef struct packed {
    bus_op_e              op;
    reg_id_e              id;
    logic [IDX_W-1:0]     idx;
    logic [SLV_SEL_W-1:0] sel;
    logic [SLV_DAT_W-1:0] dat;
  } reg_wr_t;

endpackage

`default_nettype wire

//--- ethpipe_regs.f
slv_bus_pkg.sv
ethpipe_reg_pkg.sv
slv_reg_decode.sv
time_capture.sv
dma_regs.sv
slot_ptr_regs.sv
ethpipe_regs.sv
tb_ethpipe_regs.sv

//--- ethpipe_regs.sv
`default_nettype none

module ethpipe_regs
  import slv_bus_pkg::*, ethpipe_reg_pkg::*;
#(
  parameter int NUM_TX_SLOTS    = 2,
  parameter int NUM_LOCAL_TIMES = 7
) (
  input  wire                                   clk_125,
  input  wire                                   sys_rst,
  // BAR0 slave bus
  input  wire slv_req_t                         slv_req_i,
  output logic [SLV_DAT_W-1:0]                  slv_dat_o,
  input  wire                                   rx_intr_i,
  input  wire [NUM_LOCAL_TIMES-1:0]             time_req_i,
  input  wire [NUM_TX_SLOTS-1:0][TX_PTR_W-1:0]  tx_rd_ptr_i,
  output logic                                  sys_intr_o,
  output logic [1:0]                            dma_load_o,
  output logic [DMA_LEN_W-1:0]                  dma_length_o,
  output logic [1:0][DMA_ADDR_W-1:0]            dma_addr_start_o,
  output logic [NUM_TX_SLOTS-1:0][TX_PTR_W-1:0] tx_wr_ptr_o
);

  reg_wr_t                                         reg_wr;
  bus_op_e                                         bus_op;
  wire [GCNT_WORDS-1:0][SLV_DAT_W-1:0]             gcnt_rd;
  wire [DMA_RD_N-1:0][SLV_DAT_W-1:0]               dma_rd;
  wire [PTR_RD_N-1:0][SLV_DAT_W-1:0]               ptr_rd;
  wire [TIME_IDX_N-1:0][LT_WORDS-1:0][SLV_DAT_W-1:0] time_rd;

  slv_reg_decode u_decode (
    .clk_125   (clk_125),
    .sys_rst   (sys_rst),
    .slv_req_i (slv_req_i),
    .gcnt_rd_i (gcnt_rd),
    .dma_rd_i  (dma_rd),
    .ptr_rd_i  (ptr_rd),
    .time_rd_i (time_rd),
    .reg_wr_o  (reg_wr),
    .slv_dat_o (slv_dat_o),
    .bus_op_o  (bus_op)
  );

  time_capture #(
    .NUM_LOCAL_TIMES (NUM_LOCAL_TIMES)
  ) u_time (
    .clk_125    (clk_125),
    .sys_rst    (sys_rst),
    .time_req_i (time_req_i),
    .bus_op_i   (bus_op),
    .reg_wr_i   (reg_wr),
    .gcnt_rd_o  (gcnt_rd),
    .time_rd_o  (time_rd)
  );

  dma_regs u_dma (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .reg_wr_i         (reg_wr),
    .rx_intr_i        (rx_intr_i),
    .dma_rd_o         (dma_rd),
    .dma_load_o       (dma_load_o),
    .dma_length_o     (dma_length_o),
    .dma_addr_start_o (dma_addr_start_o),
    .sys_intr_o       (sys_intr_o)
  );

  slot_ptr_regs #(
    .NUM_TX_SLOTS (NUM_TX_SLOTS)
  ) u_slot (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .reg_wr_i    (reg_wr),
    .tx_rd_ptr_i (tx_rd_ptr_i),
    .tx_wr_ptr_o (tx_wr_ptr_o),
    .ptr_rd_o    (ptr_rd)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the register block testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ethpipe_regs \
  --Mdir "$OBJ" \
  -f ethpipe_regs.f

"./$OBJ/Vtb_ethpipe_regs" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished, log in $LOG"
exit 0

//--- slot_ptr_regs.sv
`default_nettype none

module slot_ptr_regs
  import slv_bus_pkg::*, ethpipe_reg_pkg::*;
#(
  parameter int NUM_TX_SLOTS = 2
) (
  input  wire                                   clk_125,
  input  wire                                   sys_rst,
  input  wire reg_wr_t                          reg_wr_i,
  input  wire [NUM_TX_SLOTS-1:0][TX_PTR_W-1:0]  tx_rd_ptr_i,
  output logic [NUM_TX_SLOTS-1:0][TX_PTR_W-1:0] tx_wr_ptr_o,
  output wire [PTR_RD_N-1:0][SLV_DAT_W-1:0]     ptr_rd_o
);

  logic wr_ptr;

  // low byte in lane 1, bits 13:8 in data 5:0
  function automatic logic [SLV_DAT_W-1:0] fmt(input logic [TX_PTR_W-1:0] p);
    return {p[7:0], 2'b00, p[13:8]};
  endfunction

  assign wr_ptr = (reg_wr_i.op == OP_WRITE) && (reg_wr_i.id == REG_TX_WR_PTR);

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      tx_wr_ptr_o <= '0;
    end else begin
      for (int s = 0; s < NUM_TX_SLOTS; s++) begin
        if (wr_ptr && reg_wr_i.idx == IDX_W'(s)) begin
          if (reg_wr_i.sel[1]) tx_wr_ptr_o[s][7:0] <= reg_wr_i.dat[15:8];
          if (reg_wr_i.sel[0]) tx_wr_ptr_o[s][13:8] <= reg_wr_i.dat[5:0];
        end
      end
    end
  end

  // slots beyond the configured count read as zero
  for (genvar s = 0; s < SLOT_IDX_N; s++) begin : g_slot
    if (s < NUM_TX_SLOTS) begin : g_used
      assign ptr_rd_o[s]              = fmt(tx_wr_ptr_o[s]);
      assign ptr_rd_o[SLOT_IDX_N + s] = fmt(tx_rd_ptr_i[s]);
    end else begin : g_unused
      assign ptr_rd_o[s]              = '0;
      assign ptr_rd_o[SLOT_IDX_N + s] = '0;
    end
  end

endmodule

`default_nettype wire

//--- slv_bus_pkg.sv
`default_nettype none

package slv_bus_pkg;

  // --------------------
  // slave bus widths
  // --------------------

  // word address, bits 19:1 of the byte address
  localparam int SLV_ADR_W = 19;
  localparam int SLV_DAT_W = 16;
  localparam int SLV_BAR_N = 7;
  // one select per byte lane
  localparam int SLV_SEL_W = SLV_DAT_W / 8;

  // one slave bus access
  typedef struct packed {
    logic [SLV_BAR_N-1:0] bar;
    logic                 ce;
    logic                 we;
    logic [SLV_ADR_W:1]   adr;
    logic [SLV_DAT_W-1:0] dat;
    logic [SLV_SEL_W-1:0] sel;
  } slv_req_t;

endpackage

`default_nettype wire

//--- slv_reg_decode.sv
`default_nettype none

module slv_reg_decode
  import slv_bus_pkg::*, ethpipe_reg_pkg::*;
(
  input  wire                                             clk_125,
  input  wire                                             sys_rst,
  input  wire slv_req_t                                   slv_req_i,
  input  wire [GCNT_WORDS-1:0][SLV_DAT_W-1:0]             gcnt_rd_i,
  input  wire [DMA_RD_N-1:0][SLV_DAT_W-1:0]               dma_rd_i,
  input  wire [PTR_RD_N-1:0][SLV_DAT_W-1:0]               ptr_rd_i,
  input  wire [TIME_IDX_N-1:0][LT_WORDS-1:0][SLV_DAT_W-1:0] time_rd_i,
  output reg_wr_t                                         reg_wr_o,
  output logic [SLV_DAT_W-1:0]                            slv_dat_o,
  output bus_op_e                                         bus_op_o
);

  logic                 acc;
  logic [7:0]           off;
  reg_id_e              id;
  logic [IDX_W-1:0]     idx;
  logic [SLV_DAT_W-1:0] rd_word;

  // BAR0 hit with chip enable
  assign acc = slv_req_i.ce & slv_req_i.bar[0];
  assign off = slv_req_i.adr[8:1];

  always_comb begin
    if (!acc) begin
      bus_op_o = OP_IDLE;
    end else if (slv_req_i.we) begin
      bus_op_o = OP_WRITE;
    end else begin
      bus_op_o = OP_READ;
    end
  end

  // --------------------
  // address decode
  // --------------------
  always_comb begin
    id  = REG_NONE;
    idx = '0;
    // only page 0 is mapped
    if (slv_req_i.adr[11:9] == 3'd0) begin
      casez (off)
        8'h02, 8'h03, 8'h04, 8'h05, 8'h08, 8'h0a, 8'h0b,
        8'h10, 8'h11, 8'h14, 8'h15: begin
          id = reg_id_e'(off);
        end
        8'b0001_100?: begin
          id  = REG_TX_WR_PTR;
          idx = IDX_W'(off[0]);
        end
        8'b0001_101?: begin
          id  = REG_TX_RD_PTR;
          idx = IDX_W'(off[0]);
        end
        // local time n at 0x80 + 4n, three words each
        8'b100?_????: begin
          if (off[1:0] != 2'd3) begin
            id  = reg_id_e'({6'b10_0000, off[1:0]});
            idx = off[4:2];
          end
        end
        default: begin
          id = REG_NONE;
        end
      endcase
    end
  end

  always_comb begin
    reg_wr_o.op  = (bus_op_o == OP_WRITE && id != REG_NONE) ? OP_WRITE : OP_IDLE;
    reg_wr_o.id  = id;
    reg_wr_o.idx = idx;
    reg_wr_o.sel = slv_req_i.sel;
    reg_wr_o.dat = slv_req_i.dat;
  end

  // --------------------
  // read data
  // --------------------
  always_comb begin
    case (id)
      REG_GCNT0:        rd_word = gcnt_rd_i[0];
      REG_GCNT1:        rd_word = gcnt_rd_i[1];
      REG_GCNT2:        rd_word = gcnt_rd_i[2];
      REG_GCNT3:        rd_word = gcnt_rd_i[3];
      REG_DMA_STATUS:   rd_word = dma_rd_i[DRD_STATUS];
      REG_DMA_LEN_LO:   rd_word = dma_rd_i[DRD_LEN_LO];
      REG_DMA_LEN_HI:   rd_word = dma_rd_i[DRD_LEN_HI];
      REG_DMA1_ADDR_LO: rd_word = dma_rd_i[DRD_A1_LO];
      REG_DMA1_ADDR_HI: rd_word = dma_rd_i[DRD_A1_HI];
      REG_DMA2_ADDR_LO: rd_word = dma_rd_i[DRD_A1_LO + 2];
      REG_DMA2_ADDR_HI: rd_word = dma_rd_i[DRD_A1_HI + 2];
      REG_TX_WR_PTR:    rd_word = ptr_rd_i[{1'b0, idx[0]}];
      REG_TX_RD_PTR:    rd_word = ptr_rd_i[{1'b1, idx[0]}];
      REG_LTIME_W0:     rd_word = time_rd_i[idx][0];
      REG_LTIME_W1:     rd_word = time_rd_i[idx][1];
      REG_LTIME_W2:     rd_word = time_rd_i[idx][2];
      default:          rd_word = '0;
    endcase
  end

  // held until the next read
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      slv_dat_o <= '0;
    end else if (bus_op_o == OP_READ) begin
      slv_dat_o <= rd_word;
    end
  end

  // every write strobe names a register of the map
  assert property (@(posedge clk_125) disable iff (sys_rst)
    reg_wr_o.op == OP_WRITE |-> reg_wr_o.id inside {
      REG_GCNT0, REG_GCNT1, REG_GCNT2, REG_GCNT3, REG_DMA_STATUS,
      REG_DMA_LEN_LO, REG_DMA_LEN_HI, REG_DMA1_ADDR_LO, REG_DMA1_ADDR_HI,
      REG_DMA2_ADDR_LO, REG_DMA2_ADDR_HI, REG_TX_WR_PTR, REG_TX_RD_PTR,
      REG_LTIME_W0, REG_LTIME_W1, REG_LTIME_W2});

endmodule

`default_nettype wire

//--- tb_ethpipe_regs.sv
`default_nettype none

module tb_ethpipe_regs
  import slv_bus_pkg::*, ethpipe_reg_pkg::*;
();

  localparam int CLK_HALF = 10;
  localparam int N_SLOTS  = 2;
  localparam int N_TIMES  = 7;
  localparam int RAND_OPS = 48;
  // worst case cycles of each test, in run order
  localparam int TEST_CYCLES = 6 + 6 + 32 + 3 * RAND_OPS + 10 + 36 + 16 + 3;

  localparam logic [7:0]  LO_OFF [3]   = '{REG_DMA_LEN_LO, REG_DMA1_ADDR_LO, REG_DMA2_ADDR_LO};
  localparam logic [7:0]  HI_OFF [3]   = '{REG_DMA_LEN_HI, REG_DMA1_ADDR_HI, REG_DMA2_ADDR_HI};
  // byte address view, a length ends at bit 21
  localparam logic [31:0] DMA_MASK [3] = '{32'h003f_fffc, 32'hffff_fffc, 32'hffff_fffc};
  localparam logic [1:0]  DMA_LOAD [3] = '{2'b11, 2'b01, 2'b10};

  logic                             clk_125;
  logic                             sys_rst;
  slv_req_t                         slv_req;
  logic                             rx_intr;
  logic [N_TIMES-1:0]               time_req;
  logic [N_SLOTS-1:0][TX_PTR_W-1:0] tx_rd_ptr;
  logic [SLV_DAT_W-1:0]             slv_dat;
  logic                             sys_intr;
  logic [1:0]                       dma_load;
  logic [DMA_LEN_W-1:0]             dma_length;
  logic [1:0][DMA_ADDR_W-1:0]       dma_addr_start;
  logic [N_SLOTS-1:0][TX_PTR_W-1:0] tx_wr_ptr;

  // expected outputs, driven with the stimulus and delayed one edge
  logic                             rd_en;
  logic [15:0]                      dat_exp;
  logic [15:0]                      dat_q;
  logic [1:0]                       load_exp;
  logic [1:0]                       load_q;
  logic                             intr_exp;
  logic                             intr_q;
  logic [N_SLOTS-1:0][TX_PTR_W-1:0] ptr_exp;
  logic [N_SLOTS-1:0][TX_PTR_W-1:0] ptr_q;
  logic [DMA_LEN_W-1:0]             len_exp;
  logic [DMA_LEN_W-1:0]             len_q;
  logic [1:0][DMA_ADDR_W-1:0]       addr_exp;
  logic [1:0][DMA_ADDR_W-1:0]       addr_q;
  logic [63:0]                      cyc;

  // register model
  logic [31:0]             dma_b [3];
  logic [TX_PTR_W-1:0]     ptr_m [N_SLOTS];
  logic [7:0]              status_m;
  logic [LOCAL_TIME_W-1:0] ltime_m [N_TIMES];
  logic [15:0]             lfsr = 16'd21505;

  ethpipe_regs dut (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .slv_req_i        (slv_req),
    .slv_dat_o        (slv_dat),
    .rx_intr_i        (rx_intr),
    .time_req_i       (time_req),
    .tx_rd_ptr_i      (tx_rd_ptr),
    .sys_intr_o       (sys_intr),
    .dma_load_o       (dma_load),
    .dma_length_o     (dma_length),
    .dma_addr_start_o (dma_addr_start),
    .tx_wr_ptr_o      (tx_wr_ptr)
  );

  initial clk_125 = 1'b0;
  always #CLK_HALF clk_125 = ~clk_125;

  always @(posedge clk_125) begin
    if (sys_rst) begin
      cyc    <= '0;
      dat_q  <= '0;
      load_q <= '0;
      intr_q <= 1'b0;
      ptr_q  <= '0;
      // reset values of the model
      len_q  <= len_exp;
      addr_q <= addr_exp;
    end else begin
      cyc    <= cyc + 64'd1;
      dat_q  <= dat_exp;
      load_q <= load_exp;
      intr_q <= intr_exp;
      ptr_q  <= ptr_exp;
      len_q  <= len_exp;
      addr_q <= addr_exp;
    end
  end

  // --------------------
  // helpers
  // --------------------
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      r    = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  // register lower byte travels in lane 1
  function automatic logic [15:0] lane_order(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

  function automatic logic [15:0] dma_word(input int r, input logic hi);
    return hi ? lane_order(dma_b[r][31:16]) : lane_order(dma_b[r][15:0]);
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
    $display("TESTBENCH FAILED");
    $fatal(1, "output mismatch");
  endtask

  task automatic drive_cycle(input logic acc, input logic we, input logic [2:0] page,
                             input logic [7:0] off, input logic [15:0] dat,
                             input logic [1:0] sel, input logic [15:0] exp_word,
                             input logic [1:0] ld);
    slv_req_t r;
    r       = '0;
    r.bar   = {6'd0, acc};
    r.ce    = acc;
    r.we    = we;
    r.adr   = {8'd0, page, off};
    r.dat   = dat;
    r.sel   = sel;
    slv_req  <= r;
    rd_en    <= acc & ~we;
    dat_exp  <= exp_word;
    load_exp <= ld;
    @(posedge clk_125);
  endtask

  task automatic read_reg(input logic [2:0] page, input logic [7:0] off,
                          input logic [15:0] exp_word);
    drive_cycle(1'b1, 1'b0, page, off, 16'h0000, 2'b00, exp_word, 2'b00);
  endtask

  task automatic write_reg(input logic [7:0] off, input logic [15:0] dat,
                           input logic [1:0] sel, input logic [1:0] ld);
    drive_cycle(1'b1, 1'b1, 3'd0, off, dat, sel, 16'h0000, ld);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, 3'd0, 8'h00, 16'h0000, 2'b00, 16'h0000, 2'b00);
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic reset_readback();
    for (int r = 0; r < 3; r++) begin
      read_reg(3'd0, LO_OFF[r], dma_word(r, 1'b0));
      read_reg(3'd0, HI_OFF[r], dma_word(r, 1'b1));
    end
  endtask

  task automatic counter_readback();
    logic [63:0] c;
    for (int w = 0; w < 4; w++) begin
      idle_cycles(int'(rand_bits(3)));
      // counter value seen by the DUT in the access cycle
      c = cyc + 64'd1;
      read_reg(3'd0, 8'(REG_GCNT0) + 8'(w), lane_order(c[16*w +: 16]));
    end
  endtask

  task automatic random_writes();
    logic [2:0]          pick;
    logic [15:0]         dat;
    logic [1:0]          sel;
    logic [7:0]          off;
    logic [TX_PTR_W-1:0] rp;
    logic                hi;
    int                  r;
    int                  s;
    for (int i = 0; i < RAND_OPS; i++) begin
      pick = 3'(rand_bits(3));
      dat  = rand_bits(16);
      sel  = 2'(rand_bits(2));
      if (pick < 3'd6) begin
        r  = int'(pick) / 2;
        hi = pick[0];
        if (hi) begin
          if (sel[1]) dma_b[r][23:16] = dat[15:8];
          if (sel[0]) dma_b[r][31:24] = dat[7:0];
        end else begin
          if (sel[1]) dma_b[r][7:0] = dat[15:8];
          if (sel[0]) dma_b[r][15:8] = dat[7:0];
        end
        dma_b[r] = dma_b[r] & DMA_MASK[r];
        // outputs count 32-bit words
        len_exp     <= dma_b[0][21:2];
        addr_exp[0] <= dma_b[1][31:2];
        addr_exp[1] <= dma_b[2][31:2];
        off = hi ? HI_OFF[r] : LO_OFF[r];
        write_reg(off, dat, sel, DMA_LOAD[r]);
        read_reg(3'd0, off, dma_word(r, hi));
      end else begin
        s  = int'(pick[0]);
        rp = 14'(rand_bits(14));
        if (sel[1]) ptr_m[s][7:0] = dat[15:8];
        if (sel[0]) ptr_m[s][13:8] = dat[5:0];
        ptr_exp      <= {ptr_m[1], ptr_m[0]};
        tx_rd_ptr[s] <= rp;
        write_reg(8'(REG_TX_WR_PTR) + 8'(s), dat, sel, 2'b00);
        read_reg(3'd0, 8'(REG_TX_RD_PTR) + 8'(s), lane_order({2'b00, rp}));
        read_reg(3'd0, 8'(REG_TX_WR_PTR) + 8'(s), lane_order({2'b00, ptr_m[s]}));
      end
    end
  endtask

  task automatic interrupt_test();
    rx_intr  <= 1'b1;
    intr_exp <= 1'b1;
    status_m[INTR_BIT] = 1'b1;
    idle_cycles(1);
    rx_intr <= 1'b0;
    idle_cycles(1);
    read_reg(3'd0, REG_DMA_STATUS, lane_order({8'h00, status_m}));
    // lane 0 leaves the status byte alone
    write_reg(REG_DMA_STATUS, 16'h0000, 2'b01, 2'b00);
    read_reg(3'd0, REG_DMA_STATUS, lane_order({8'h00, status_m}));
    status_m = 8'h00;
    intr_exp <= 1'b0;
    write_reg(REG_DMA_STATUS, 16'h0000, 2'b10, 2'b00);
    read_reg(3'd0, REG_DMA_STATUS, 16'h0000);
  endtask

  task automatic time_capture_test();
    logic [63:0] c;
    c = cyc + 64'd1;
    time_req <= 7'b000_0100;
    idle_cycles(1);
    time_req <= '0;
    ltime_m[2] = c[47:0] + 48'd1 - 48'(CAPTURE_LAG);
    idle_cycles(3);
    // two requests, lower index goes first
    c = cyc + 64'd1;
    time_req <= 7'b101_0000;
    idle_cycles(1);
    time_req <= '0;
    ltime_m[4] = c[47:0] + 48'd1 - 48'(CAPTURE_LAG);
    ltime_m[6] = c[47:0] + 48'd2 - 48'(CAPTURE_LAG);
    idle_cycles(4);
    for (int n = 0; n < N_TIMES; n++) begin
      for (int k = 0; k < 3; k++) begin
        read_reg(3'd0, 8'(REG_LTIME_W0) + 8'(4 * n + k), lane_order(ltime_m[n][16*k +: 16]));
      end
    end
  endtask

  task automatic read_unmapped(input logic [2:0] page, input logic [7:0] off);
    logic [63:0] c;
    // nonzero counter word first, the zero read has to replace it
    c = cyc + 64'd1;
    read_reg(3'd0, REG_GCNT0, lane_order(c[15:0]));
    read_reg(page, off, 16'h0000);
  endtask

  task automatic unmapped_reads();
    read_unmapped(3'd0, 8'h00);
    read_unmapped(3'd0, 8'h06);
    read_unmapped(3'd0, 8'h1c);
    read_unmapped(3'd0, 8'h40);
    read_unmapped(3'd0, 8'h83);
    // local time 7 is beyond the configured count
    read_unmapped(3'd0, 8'h9c);
    read_unmapped(3'd1, REG_GCNT0);
    read_unmapped(3'd4, REG_GCNT0);
  endtask

  // --------------------
  // checks
  // --------------------
  assert property (@(posedge clk_125) disable iff (sys_rst) rd_en |=> slv_dat == dat_q)
    else report_mismatch("slv_dat_o", 64'($sampled(slv_dat)), 64'($sampled(dat_q)));

  assert property (@(posedge clk_125) disable iff (sys_rst) dma_load == load_q)
    else report_mismatch("dma_load_o", 64'($sampled(dma_load)), 64'($sampled(load_q)));

  assert property (@(posedge clk_125) disable iff (sys_rst) sys_intr == intr_q)
    else report_mismatch("sys_intr_o", 64'($sampled(sys_intr)), 64'($sampled(intr_q)));

  assert property (@(posedge clk_125) disable iff (sys_rst) tx_wr_ptr == ptr_q)
    else report_mismatch("tx_wr_ptr_o", 64'($sampled(tx_wr_ptr)), 64'($sampled(ptr_q)));

  assert property (@(posedge clk_125) disable iff (sys_rst) dma_length == len_q)
    else report_mismatch("dma_length_o", 64'($sampled(dma_length)), 64'($sampled(len_q)));

  assert property (@(posedge clk_125) disable iff (sys_rst) dma_addr_start == addr_q)
    else report_mismatch("dma_addr_start_o", 64'($sampled(dma_addr_start)),
                         64'($sampled(addr_q)));

  initial begin
    #(2 * TEST_CYCLES * 2 * CLK_HALF);
    $display("watchdog: tests did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    sys_rst   = 1'b1;
    slv_req   = '0;
    rx_intr   = 1'b0;
    time_req  = '0;
    tx_rd_ptr = '0;
    rd_en     = 1'b0;
    dat_exp   = '0;
    load_exp  = '0;
    intr_exp  = 1'b0;
    ptr_exp   = '0;
    status_m  = 8'h00;
    dma_b[0]  = 32'h0001_0000;
    dma_b[1]  = 32'h1000_0000;
    dma_b[2]  = 32'h1010_0000;
    len_exp     = dma_b[0][21:2];
    addr_exp[0] = dma_b[1][31:2];
    addr_exp[1] = dma_b[2][31:2];
    for (int s = 0; s < N_SLOTS; s++) ptr_m[s] = '0;
    for (int n = 0; n < N_TIMES; n++) ltime_m[n] = '0;
    repeat (5) @(posedge clk_125);
    sys_rst <= 1'b0;
    idle_cycles(1);
    reset_readback();
    counter_readback();
    random_writes();
    interrupt_test();
    time_capture_test();
    unmapped_reads();
    idle_cycles(3);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- time_capture.sv
`default_nettype none

module time_capture
  import slv_bus_pkg::*, ethpipe_reg_pkg::*;
#(
  parameter int NUM_LOCAL_TIMES = 7
) (
  input  wire                                              clk_125,
  input  wire                                              sys_rst,
  input  wire [NUM_LOCAL_TIMES-1:0]                        time_req_i,
  input  wire bus_op_e                                     bus_op_i,
  input  wire reg_wr_t                                     reg_wr_i,
  output logic [GCNT_WORDS-1:0][SLV_DAT_W-1:0]             gcnt_rd_o,
  output wire [TIME_IDX_N-1:0][LT_WORDS-1:0][SLV_DAT_W-1:0] time_rd_o
);

  logic [GCNT_W-1:0]          gcnt;
  logic [NUM_LOCAL_TIMES-1:0] pending;
  logic [NUM_LOCAL_TIMES-1:0] grant;
  logic                       ack;
  logic                       fire;
  logic                       wr_time;
  logic [1:0]                 wr_k;
  logic [LOCAL_TIME_W-1:0]    ltime [NUM_LOCAL_TIMES];

  // host sees the lower byte in lane 1
  function automatic logic [SLV_DAT_W-1:0] swap16(input logic [SLV_DAT_W-1:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  // lowest pending index wins
  assign grant = pending & (~pending + 1'b1);
  // capture only while the bus is idle
  assign fire  = (bus_op_i == OP_IDLE) && (pending != '0);

  assign wr_time = (reg_wr_i.op == OP_WRITE) &&
                   (reg_wr_i.id inside {REG_LTIME_W0, REG_LTIME_W1, REG_LTIME_W2});
  // word k sits in the low id bits
  assign wr_k    = reg_wr_i.id[1:0];

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      gcnt    <= '0;
      pending <= '0;
      ack     <= 1'b0;
      for (int n = 0; n < NUM_LOCAL_TIMES; n++) begin
        ltime[n] <= '0;
      end
    end else begin
      gcnt <= gcnt + 1'b1;
      ack  <= fire;
      // a new request replaces older pending bits
      if (time_req_i != '0) begin
        pending <= time_req_i;
      end else if (fire) begin
        pending <= pending & ~grant;
      end
      for (int n = 0; n < NUM_LOCAL_TIMES; n++) begin
        if (fire && grant[n]) begin
          ltime[n] <= gcnt[LOCAL_TIME_W-1:0] - LOCAL_TIME_W'(CAPTURE_LAG);
        end else if (wr_time && reg_wr_i.idx == IDX_W'(n)) begin
          if (reg_wr_i.sel[1]) ltime[n][16*wr_k +: 8] <= reg_wr_i.dat[15:8];
          if (reg_wr_i.sel[0]) ltime[n][16*wr_k+8 +: 8] <= reg_wr_i.dat[7:0];
        end
      end
    end
  end

  // --------------------
  // read words
  // --------------------
  always_comb begin
    for (int w = 0; w < GCNT_WORDS; w++) begin
      gcnt_rd_o[w] = swap16(gcnt[16*w +: 16]);
    end
  end

  for (genvar n = 0; n < TIME_IDX_N; n++) begin : g_time
    for (genvar k = 0; k < LT_WORDS; k++) begin : g_word
      if (n < NUM_LOCAL_TIMES) begin : g_used
        assign time_rd_o[n][k] = swap16(ltime[n][16*k +: 16]);
      end else begin : g_unused
        assign time_rd_o[n][k] = '0;
      end
    end
  end

  // a served request stops pending unless a new one came in
  assert property (@(posedge clk_125) disable iff (sys_rst)
    ack && ($past(time_req_i) == '0) |-> (pending & $past(grant)) == '0);

endmodule

`default_nettype wire
